/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
TOP       := tb_image_filter
RTL_TOP   := image_filter_top
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Verification failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation run FAILED, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
source/image_filter_pkg.sv
source/video_timing.sv
source/filter_config.sv
source/point_filter.sv
source/kernel_filter.sv
source/video_output.sv
source/image_filter_top.sv
test/tb_image_filter.sv

/* source/filter_config.sv */
`default_nettype none

module filter_config (
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                frame_end_i,
   input  wire image_filter_pkg::mode_t       mode_i,
   input  wire image_filter_pkg::pixel_t      adj_i,
   output image_filter_pkg::filter_cfg_t      cfg_o
);

   import image_filter_pkg::*;

   // settings only move between frames
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_o <= '{mode: MODE_ORIGINAL, adj: 8'h00};
      end else if (frame_end_i) begin
         cfg_o <= '{mode: mode_i, adj: adj_i};
      end
   end

   // no mode switch inside a frame
   cfg_frame_locked: assert property (
      @(posedge clk) disable iff (reset)
      (cfg_o != $past(cfg_o)) |-> $past(frame_end_i)
   );

endmodule

`default_nettype wire

/* source/image_filter_pkg.sv */
`default_nettype none

package image_filter_pkg;

   ////////////////////////////////////////
   // pixel types
   ////////////////////////////////////////

   typedef logic [7:0] pixel_t;

   typedef struct packed {
      pixel_t red;
      pixel_t green;
      pixel_t blue;
   } rgb24_t;

   // upper nibble of each channel, as sent to the monitor
   typedef struct packed {
      logic [3:0] red;
      logic [3:0] green;
      logic [3:0] blue;
   } rgb12_t;

   // 3x3 grayscale window around the current pixel
   typedef struct packed {
      pixel_t centre;
      pixel_t left;
      pixel_t right;
      pixel_t up;
      pixel_t down;
      pixel_t left_up;
      pixel_t left_down;
      pixel_t right_up;
      pixel_t right_down;
   } nbhd_t;

   ////////////////////////////////////////
   // filter modes
   ////////////////////////////////////////

   // codes 9, 11, 12 and 14 are reserved and give black
   typedef enum logic [3:0] {
      MODE_GRAY      = 4'd0,
      MODE_BRIGHTEN  = 4'd1,
      MODE_DARKEN    = 4'd2,
      MODE_INVERT    = 4'd3,
      MODE_RED_CUT   = 4'd4,
      MODE_BLUE_CUT  = 4'd5,
      MODE_GREEN_CUT = 4'd6,
      MODE_ORIGINAL  = 4'd7,
      MODE_BOX_BLUR  = 4'd8,
      MODE_EDGE      = 4'd10,
      MODE_SHARPEN   = 4'd13,
      MODE_GAUSSIAN  = 4'd15
   } mode_t;

   typedef struct packed {
      mode_t  mode;
      pixel_t adj;
   } filter_cfg_t;

   ////////////////////////////////////////
   // raster timing
   ////////////////////////////////////////

   typedef struct packed {
      logic [9:0] h_active;
      logic [9:0] h_front;
      logic [9:0] h_sync;
      logic [9:0] h_back;
      logic [9:0] v_active;
      logic [9:0] v_front;
      logic [9:0] v_sync;
      logic [9:0] v_back;
      logic [9:0] win_x;
      logic [9:0] win_y;
      logic [9:0] win_w;
      logic [9:0] win_h;
   } video_geom_t;

   // 640x480 visible, 800x524 total, 160x115 image window
   localparam video_geom_t VGA_GEOM = '{
      h_active: 10'd640, h_front: 10'd16, h_sync: 10'd96, h_back: 10'd48,
      v_active: 10'd480, v_front: 10'd11, v_sync: 10'd2,  v_back: 10'd31,
      win_x:    10'd100, win_y:   10'd100, win_w: 10'd160, win_h: 10'd115
   };

   localparam int ADDR_W = 15;

   // beam position and the flags that go with it
   typedef struct packed {
      logic [9:0] x;
      logic [9:0] y;
      logic       active;
      logic       in_window;
      logic       hsync_n;
      logic       vsync_n;
   } beam_t;

endpackage

`default_nettype wire

/* source/image_filter_top.sv */
`default_nettype none

module image_filter_top #(
   parameter image_filter_pkg::video_geom_t GEOM = image_filter_pkg::VGA_GEOM
) (
   input  wire                                  clk,
   input  wire                                  reset,
   input  wire image_filter_pkg::mode_t         mode_i,
   input  wire image_filter_pkg::pixel_t        adj_i,
   input  wire image_filter_pkg::rgb24_t        rgb_i,
   input  wire image_filter_pkg::nbhd_t         nbhd_i,
   output logic [image_filter_pkg::ADDR_W-1:0]  pix_addr_o,
   output logic                                 hsync_o,
   output logic                                 vsync_o,
   output image_filter_pkg::rgb12_t             rgb_o
);

   import image_filter_pkg::*;

   beam_t       beam;
   logic        frame_end;
   filter_cfg_t cfg;
   rgb24_t      point_px;
   pixel_t      kernel_px;

   ////////////////////////////////////////
   // raster and per-frame settings
   ////////////////////////////////////////

   video_timing #(
      .GEOM (GEOM)
   ) u_timing (
      .clk         (clk),
      .reset       (reset),
      .beam_o      (beam),
      .frame_end_o (frame_end),
      .pix_addr_o  (pix_addr_o)
   );

   filter_config u_config (
      .clk         (clk),
      .reset       (reset),
      .frame_end_i (frame_end),
      .mode_i      (mode_i),
      .adj_i       (adj_i),
      .cfg_o       (cfg)
   );

   ////////////////////////////////////////
   // filters and output stage
   ////////////////////////////////////////

   point_filter u_point (
      .rgb_i (rgb_i),
      .cfg_i (cfg),
      .px_o  (point_px)
   );

   kernel_filter u_kernel (
      .nbhd_i (nbhd_i),
      .cfg_i  (cfg),
      .px_o   (kernel_px)
   );

   video_output u_output (
      .clk      (clk),
      .reset    (reset),
      .beam_i   (beam),
      .cfg_i    (cfg),
      .point_i  (point_px),
      .kernel_i (kernel_px),
      .hsync_o  (hsync_o),
      .vsync_o  (vsync_o),
      .rgb_o    (rgb_o)
   );

endmodule

`default_nettype wire

/* source/kernel_filter.sv */
`default_nettype none

module kernel_filter (
   input  wire image_filter_pkg::nbhd_t       nbhd_i,
   input  wire image_filter_pkg::filter_cfg_t cfg_i,
   output image_filter_pkg::pixel_t           px_o
);

   import image_filter_pkg::*;

   logic [11:0]        orth_sum;
   logic [11:0]        corner_sum;
   logic [11:0]        all_sum;
   logic [11:0]        gauss_sum;
   logic signed [12:0] edge_val;
   logic signed [12:0] sharp_val;

   function automatic pixel_t clamp8(input logic signed [12:0] v);
      if (v < 0) begin
         return 8'h00;
      end else if (v > 13'sd255) begin
         return 8'hff;
      end
      return v[7:0];
   endfunction

   // partial sums shared by all kernels
   assign orth_sum   = 12'(nbhd_i.left) + 12'(nbhd_i.right) + 12'(nbhd_i.up) + 12'(nbhd_i.down);
   assign corner_sum = 12'(nbhd_i.left_up) + 12'(nbhd_i.left_down)
                     + 12'(nbhd_i.right_up) + 12'(nbhd_i.right_down);
   assign all_sum    = 12'(nbhd_i.centre) + orth_sum + corner_sum;

   // 1-2-1 weights, total 16
   assign gauss_sum  = (12'(nbhd_i.centre) << 2) + (orth_sum << 1) + corner_sum;

   assign edge_val  = 13'sd8 * $signed({5'b0, nbhd_i.centre})
                    - $signed({1'b0, orth_sum + corner_sum});
   assign sharp_val = 13'sd5 * $signed({5'b0, nbhd_i.centre}) - $signed({1'b0, orth_sum});

   always_comb begin
      case (cfg_i.mode)
         MODE_BOX_BLUR: px_o = pixel_t'(all_sum / 12'd9);
         MODE_EDGE:     px_o = clamp8(edge_val);
         MODE_SHARPEN:  px_o = clamp8(sharp_val);
         MODE_GAUSSIAN: px_o = gauss_sum[11:4];
         default:       px_o = 8'h00;
      endcase
   end

endmodule

`default_nettype wire

/* source/point_filter.sv */
`default_nettype none

module point_filter (
   input  wire image_filter_pkg::rgb24_t      rgb_i,
   input  wire image_filter_pkg::filter_cfg_t cfg_i,
   output image_filter_pkg::rgb24_t           px_o
);

   import image_filter_pkg::*;

   pixel_t gray;

   function automatic pixel_t sat_add(input pixel_t a, input pixel_t b);
      logic [8:0] s;
      s = {1'b0, a} + {1'b0, b};
      return s[8] ? 8'hff : s[7:0];
   endfunction

   function automatic pixel_t sat_sub(input pixel_t a, input pixel_t b);
      return (a > b) ? pixel_t'(a - b) : 8'h00;
   endfunction

   // luma approximation by shifts, peaks at 234 so no carry out
   assign gray = (rgb_i.red >> 2) + (rgb_i.red >> 5)
               + (rgb_i.green >> 1) + (rgb_i.green >> 4)
               + (rgb_i.blue >> 4) + (rgb_i.blue >> 5);

   always_comb begin
      px_o = rgb_i;
      case (cfg_i.mode)
         MODE_GRAY: begin
            px_o = '{red: gray, green: gray, blue: gray};
         end
         MODE_BRIGHTEN: begin
            px_o.red   = sat_add(rgb_i.red, cfg_i.adj);
            px_o.green = sat_add(rgb_i.green, cfg_i.adj);
            px_o.blue  = sat_add(rgb_i.blue, cfg_i.adj);
         end
         MODE_DARKEN: begin
            px_o.red   = sat_sub(rgb_i.red, cfg_i.adj);
            px_o.green = sat_sub(rgb_i.green, cfg_i.adj);
            px_o.blue  = sat_sub(rgb_i.blue, cfg_i.adj);
         end
         MODE_INVERT: begin
            px_o = ~rgb_i;
         end
         MODE_RED_CUT:   px_o.red   = sat_sub(rgb_i.red, cfg_i.adj);
         MODE_BLUE_CUT:  px_o.blue  = sat_sub(rgb_i.blue, cfg_i.adj);
         MODE_GREEN_CUT: px_o.green = sat_sub(rgb_i.green, cfg_i.adj);
         // original and the kernel codes pass the pixel through
         default: px_o = rgb_i;
      endcase
   end

endmodule

`default_nettype wire

/* source/video_output.sv */
`default_nettype none

module video_output (
   input  wire                                clk,
   input  wire                                reset,
   input  wire image_filter_pkg::beam_t       beam_i,
   input  wire image_filter_pkg::filter_cfg_t cfg_i,
   input  wire image_filter_pkg::rgb24_t      point_i,
   input  wire image_filter_pkg::pixel_t      kernel_i,
   output logic                               hsync_o,
   output logic                               vsync_o,
   output image_filter_pkg::rgb12_t           rgb_o
);

   import image_filter_pkg::*;

   // beam one cycle late, in step with the store data
   beam_t  beam_d;
   rgb24_t sel_px;
   logic   show;

   assign show = beam_d.active && beam_d.in_window;

   always_comb begin
      sel_px = '0;
      if (show) begin
         case (cfg_i.mode)
            MODE_BOX_BLUR, MODE_EDGE, MODE_SHARPEN, MODE_GAUSSIAN: begin
               sel_px = '{red: kernel_i, green: kernel_i, blue: kernel_i};
            end
            // point codes 0..7, reserved codes stay black
            default: begin
               if (!cfg_i.mode[3]) begin
                  sel_px = point_i;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         beam_d  <= '{x: '0, y: '0, active: 1'b0, in_window: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1};
         hsync_o <= 1'b1;
         vsync_o <= 1'b1;
         rgb_o   <= '0;
      end else begin
         beam_d  <= beam_i;
         hsync_o <= beam_d.hsync_n;
         vsync_o <= beam_d.vsync_n;
         rgb_o   <= '{red: sel_px.red[7:4], green: sel_px.green[7:4], blue: sel_px.blue[7:4]};
      end
   end

endmodule

`default_nettype wire

/* source/video_timing.sv */
`default_nettype none

module video_timing #(
   parameter image_filter_pkg::video_geom_t GEOM = image_filter_pkg::VGA_GEOM
) (
   input  wire                                  clk,
   input  wire                                  reset,
   output image_filter_pkg::beam_t              beam_o,
   output logic                                 frame_end_o,
   output logic [image_filter_pkg::ADDR_W-1:0]  pix_addr_o
);

   import image_filter_pkg::*;

   // horizontal landmarks
   localparam logic [10:0] H_SYNC_START = GEOM.h_active + GEOM.h_front;
   localparam logic [10:0] H_SYNC_END   = H_SYNC_START + GEOM.h_sync;
   localparam logic [10:0] H_TOTAL      = H_SYNC_END + GEOM.h_back;

   // vertical landmarks
   localparam logic [10:0] V_SYNC_START = GEOM.v_active + GEOM.v_front;
   localparam logic [10:0] V_SYNC_END   = V_SYNC_START + GEOM.v_sync;
   localparam logic [10:0] V_TOTAL      = V_SYNC_END + GEOM.v_back;

   localparam logic [10:0] X_END = GEOM.win_x + GEOM.win_w;
   localparam logic [10:0] Y_END = GEOM.win_y + GEOM.win_h;
   localparam int unsigned WIN_SIZE = GEOM.win_w * GEOM.win_h;

   logic [9:0]        h_nxt;
   logic [9:0]        v_nxt;
   beam_t             beam_nxt;
   logic              last_nxt;
   logic              first_nxt;
   logic [ADDR_W-1:0] addr_nxt;

   // flags for a given position
   function automatic beam_t make_beam(input logic [9:0] x, input logic [9:0] y);
      beam_t b;
      b.x         = x;
      b.y         = y;
      b.active    = (x < GEOM.h_active) && (y < GEOM.v_active);
      b.in_window = (x >= GEOM.win_x) && (x < X_END) && (y >= GEOM.win_y) && (y < Y_END);
      b.hsync_n   = !((x >= H_SYNC_START) && (x < H_SYNC_END));
      b.vsync_n   = !((y >= V_SYNC_START) && (y < V_SYNC_END));
      return b;
   endfunction

   ////////////////////////////////////////
   // next beam position
   ////////////////////////////////////////

   always_comb begin
      if (beam_o.x == H_TOTAL - 11'd1) begin
         h_nxt = '0;
         v_nxt = (beam_o.y == V_TOTAL - 11'd1) ? '0 : beam_o.y + 10'd1;
      end else begin
         h_nxt = beam_o.x + 10'd1;
         v_nxt = beam_o.y;
      end
   end

   assign beam_nxt  = make_beam(h_nxt, v_nxt);
   assign last_nxt  = (h_nxt == H_TOTAL - 11'd1) && (v_nxt == V_TOTAL - 11'd1);
   assign first_nxt = (h_nxt == GEOM.win_x) && (v_nxt == GEOM.win_y);

   // address restarts on the window origin and wraps at the window size
   always_comb begin
      if (first_nxt || pix_addr_o == ADDR_W'(WIN_SIZE - 1)) begin
         addr_nxt = '0;
      end else begin
         addr_nxt = pix_addr_o + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         beam_o      <= make_beam('0, '0);
         frame_end_o <= 1'b0;
         pix_addr_o  <= '0;
      end else begin
         beam_o      <= beam_nxt;
         frame_end_o <= last_nxt;
         // hold the address outside the window
         if (beam_nxt.in_window) begin
            pix_addr_o <= addr_nxt;
         end
      end
   end

   addr_in_range: assert property (
      @(posedge clk) disable iff (reset) pix_addr_o < WIN_SIZE
   );

   frame_end_single: assert property (
      @(posedge clk) disable iff (reset) frame_end_o |=> !frame_end_o
   );

endmodule

`default_nettype wire

/* test/tb_image_filter.sv */
`default_nettype none

module tb_image_filter;

   timeunit 1ns;
   timeprecision 1ps;

   import image_filter_pkg::*;

   // small raster, 32 x 16 total, 8 x 6 window
   localparam video_geom_t TB_GEOM = '{
      h_active: 10'd24, h_front: 10'd2, h_sync: 10'd3, h_back: 10'd3,
      v_active: 10'd12, v_front: 10'd1, v_sync: 10'd2, v_back: 10'd1,
      win_x:    10'd4,  win_y:   10'd3, win_w:  10'd8, win_h:  10'd6
   };

   localparam int H_TOTAL   = TB_GEOM.h_active + TB_GEOM.h_front + TB_GEOM.h_sync + TB_GEOM.h_back;
   localparam int V_TOTAL   = TB_GEOM.v_active + TB_GEOM.v_front + TB_GEOM.v_sync + TB_GEOM.v_back;
   localparam int HS_START  = TB_GEOM.h_active + TB_GEOM.h_front;
   localparam int VS_START  = TB_GEOM.v_active + TB_GEOM.v_front;
   localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
   localparam int WIN_SIZE  = TB_GEOM.win_w * TB_GEOM.win_h;
   localparam int NUM_FRAMES = 17;
   localparam int CLK_PERIOD = 20;
   localparam int RESET_CYCLES = 8;
   localparam longint WATCHDOG_NS = longint'(NUM_FRAMES + 2) * FRAME_LEN * CLK_PERIOD;

   logic                clk;
   logic                reset;
   mode_t               mode_i;
   pixel_t              adj_i;
   rgb24_t              rgb_i;
   nbhd_t               nbhd_i;
   logic [ADDR_W-1:0]   pix_addr_o;
   logic                hsync_o;
   logic                vsync_o;
   rgb12_t              rgb_o;

   logic [31:0]         lfsr_state;
   int                  prev_addr = 0;
   rgb24_t              store_rgb [WIN_SIZE];
   nbhd_t               store_nbhd [WIN_SIZE];
   int                  frame_code [NUM_FRAMES];
   pixel_t              frame_adj [NUM_FRAMES];

   image_filter_top #(
      .GEOM (TB_GEOM)
   ) UUT (
      .clk        (clk),
      .reset      (reset),
      .mode_i     (mode_i),
      .adj_i      (adj_i),
      .rgb_i      (rgb_i),
      .nbhd_i     (nbhd_i),
      .pix_addr_o (pix_addr_o),
      .hsync_o    (hsync_o),
      .vsync_o    (vsync_o),
      .rgb_o      (rgb_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   // galois lfsr, one step per bit
   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         value = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hd000_0001) : (lfsr_state >> 1);
      end
      return value;
   endfunction

   function automatic pixel_t random_pixel(input int shift);
      return pixel_t'(take_bits(8)) >> shift;
   endfunction

   function automatic int pos_x(input int n);
      return n % H_TOTAL;
   endfunction

   function automatic int pos_y(input int n);
      return (n / H_TOTAL) % V_TOTAL;
   endfunction

   function automatic bit in_window(input int x, input int y);
      return x >= TB_GEOM.win_x && x < TB_GEOM.win_x + TB_GEOM.win_w
          && y >= TB_GEOM.win_y && y < TB_GEOM.win_y + TB_GEOM.win_h
          && x < TB_GEOM.h_active && y < TB_GEOM.v_active;
   endfunction

   function automatic int window_index(input int x, input int y);
      return (y - TB_GEOM.win_y) * TB_GEOM.win_w + (x - TB_GEOM.win_x);
   endfunction

   function automatic int clamp_byte(input int v);
      return (v < 0) ? 0 : ((v > 255) ? 255 : v);
   endfunction

   // expected colour for one position under one frame setting
   function automatic rgb12_t expected_rgb(input int code, input int adj, input rgb24_t px,
                                           input nbhd_t nb, input int x, input int y);
      int r;
      int g;
      int b;
      int c;
      int orth;
      int corner;
      rgb12_t res;
      r = px.red;
      g = px.green;
      b = px.blue;
      c = nb.centre;
      orth = nb.left + nb.right + nb.up + nb.down;
      corner = nb.left_up + nb.left_down + nb.right_up + nb.right_down;
      res = '0;
      if (!in_window(x, y)) begin
         return res;
      end
      case (code)
         0: begin
            r = (px.red >> 2) + (px.red >> 5) + (px.green >> 1) + (px.green >> 4)
              + (px.blue >> 4) + (px.blue >> 5);
            g = r;
            b = r;
         end
         1: begin
            r = clamp_byte(r + adj);
            g = clamp_byte(g + adj);
            b = clamp_byte(b + adj);
         end
         2: begin
            r = clamp_byte(r - adj);
            g = clamp_byte(g - adj);
            b = clamp_byte(b - adj);
         end
         3: begin
            r = 255 - r;
            g = 255 - g;
            b = 255 - b;
         end
         4: r = clamp_byte(r - adj);
         5: b = clamp_byte(b - adj);
         6: g = clamp_byte(g - adj);
         7: r = r;
         8: r = (c + orth + corner) / 9;
         10: r = clamp_byte(8 * c - orth - corner);
         13: r = clamp_byte(5 * c - orth);
         15: r = (4 * c + 2 * orth + corner) / 16;
         default: r = 0;
      endcase
      // kernel and reserved codes give one gray value
      if (code >= 8) begin
         g = r;
         b = r;
      end
      res.red   = 4'(r >> 4);
      res.green = 4'(g >> 4);
      res.blue  = 4'(b >> 4);
      return res;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                  $time);
         $display("Verification failed");
         $fatal(1, "stopped at the first wrong value");
      end
   endtask

   // new image contents, with saturating and clamping entries
   task automatic fill_store();
      nbhd_t nb;
      for (int a = 0; a < WIN_SIZE; a++) begin
         store_rgb[a] = rgb24_t'(take_bits(24));
         nb.centre     = random_pixel(0);
         nb.left       = random_pixel(a % 8 == 0 ? 3 : 0);
         nb.right      = random_pixel(a % 8 == 0 ? 3 : 0);
         nb.up         = random_pixel(a % 8 == 0 ? 3 : 0);
         nb.down       = random_pixel(a % 8 == 0 ? 3 : 0);
         nb.left_up    = random_pixel(a % 8 == 0 ? 3 : 0);
         nb.left_down  = random_pixel(a % 8 == 0 ? 3 : 0);
         nb.right_up   = random_pixel(a % 8 == 0 ? 3 : 0);
         nb.right_down = random_pixel(a % 8 == 0 ? 3 : 0);
         if (a % 8 == 0) begin
            store_rgb[a] = '{red: 8'hff, green: 8'hff, blue: 8'hff};
            nb.centre = 8'hff;
         end else if (a % 8 == 1) begin
            store_rgb[a] = '0;
            nb.centre = 8'h00;
         end
         store_nbhd[a] = nb;
      end
   endtask

   ////////////////////////////////////////
   // image store, one cycle read latency
   ////////////////////////////////////////

   always @(negedge clk) begin
      if (prev_addr < WIN_SIZE) begin
         rgb_i  = store_rgb[prev_addr];
         nbhd_i = store_nbhd[prev_addr];
      end
      prev_addr = int'(pix_addr_o);
   end

   ////////////////////////////////////////
   // stimulus and address checks
   ////////////////////////////////////////

   initial begin : stimulus
      int x;
      int y;
      int f;
      int exp_addr;
      lfsr_state = 32'hc179_ef84;
      reset = 1'b1;
      mode_i = MODE_ORIGINAL;
      adj_i = '0;
      rgb_i = '0;
      nbhd_i = '0;
      exp_addr = 0;
      // frame 0 runs on the reset settings
      frame_code = '{7, 0, 1, 2, 3, 4, 5, 6, 7, 8, 10, 13, 15, 9, 11, 12, 14};
      frame_adj[0] = '0;
      for (f = 1; f < NUM_FRAMES; f++) begin
         frame_adj[f] = random_pixel(0) | 8'h20;
      end
      fill_store();
      repeat (RESET_CYCLES) @(negedge clk);
      check_value("hsync_o", 32'(hsync_o), 32'h1);
      check_value("vsync_o", 32'(vsync_o), 32'h1);
      check_value("rgb_o", 32'(rgb_o), 32'h0);
      check_value("pix_addr_o", 32'(pix_addr_o), 32'h0);
      reset = 1'b0;
      for (int n = 1; n <= NUM_FRAMES * FRAME_LEN; n++) begin
         @(negedge clk);
         x = pos_x(n);
         y = pos_y(n);
         f = n / FRAME_LEN;
         if (in_window(x, y)) begin
            exp_addr = window_index(x, y);
         end
         check_value("pix_addr_o", 32'(pix_addr_o), 32'(exp_addr));
         if (n % FRAME_LEN == 0) begin
            fill_store();
         end
         // next frame's settings arrive mid-window
         if (n % FRAME_LEN == 5 * H_TOTAL && f + 1 < NUM_FRAMES) begin
            mode_i = mode_t'(frame_code[f + 1]);
            adj_i  = frame_adj[f + 1];
         end
      end
   end

   ////////////////////////////////////////
   // output comparison, two cycles late
   ////////////////////////////////////////

   initial begin : compare_outputs
      int x;
      int y;
      int f;
      int idx;
      rgb24_t px;
      nbhd_t nb;
      @(negedge reset);
      @(negedge clk);
      for (int m = 0; m < NUM_FRAMES * FRAME_LEN; m++) begin
         @(negedge clk);
         x = pos_x(m);
         y = pos_y(m);
         f = m / FRAME_LEN;
         px = '0;
         nb = '0;
         if (in_window(x, y)) begin
            idx = window_index(x, y);
            px = store_rgb[idx];
            nb = store_nbhd[idx];
         end
         check_value("hsync_o", 32'(hsync_o),
                     32'(!(x >= HS_START && x < HS_START + TB_GEOM.h_sync)));
         check_value("vsync_o", 32'(vsync_o),
                     32'(!(y >= VS_START && y < VS_START + TB_GEOM.v_sync)));
         check_value("rgb_o", 32'(rgb_o),
                     32'(expected_rgb(frame_code[f], frame_adj[f], px, nb, x, y)));
      end
      $display("Verification passed");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: the run did not reach its last frame in time");
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire
